// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_mem_stage -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
+incdir+logic
logic/lsu_op_pkg.sv
logic/lsu_stage_pkg.sv
logic/mem_access_align.sv
logic/stage_reg.sv
logic/data_ram.sv
logic/load_align.sv
logic/mem_stage.sv
verification/tb_mem_stage.sv

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module data_ram (
    input  wire                    clk,
    input  logic                   wr_en,
    input  logic [3:0]             wr_strb,
    input  logic [`LSU_RAM_AW-1:0] addr,
    input  logic [31:0]            wr_data,
    output logic [31:0]            rd_data
);

    logic [31:0] mem [`LSU_RAM_WORDS];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) begin
                    mem[addr][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // read returns the word as it was before this edge's write
    always_ff @(posedge clk) begin
        rd_data <= mem[addr];
    end

    a_wr_has_strobe: assert property (@(posedge clk) wr_en |-> (wr_strb != 4'b0000))
        else $error("RAM write with no byte strobe");

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align
    import lsu_op_pkg::*, lsu_stage_pkg::*;
(
    input  mem_req_t    req,
    input  logic [31:0] ram_rdata,
    output logic [31:0] r_data
);

    logic [1:0]  off;
    logic [31:0] rt;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign off = req.ex.ls_addr[1:0];
    assign rt  = req.ex.rt_data;

    assign byte_lane = ram_rdata[8*off +: 8];
    assign half_lane = off[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        r_data = 32'h0;
        if (req.ex.ls_ena && !req.data_adel) begin
            case (req.ex.ls_sel)
                LS_LB:  r_data = {{24{byte_lane[7]}}, byte_lane};
                LS_LBU: r_data = {24'h0, byte_lane};
                LS_LH:  r_data = {{16{half_lane[15]}}, half_lane};
                LS_LHU: r_data = {16'h0, half_lane};
                LS_LW:  r_data = ram_rdata;
                // low RAM bytes fill the top of rt
                LS_LWL: begin
                    case (off)
                        2'd0:    r_data = {ram_rdata[7:0], rt[23:0]};
                        2'd1:    r_data = {ram_rdata[15:0], rt[15:0]};
                        2'd2:    r_data = {ram_rdata[23:0], rt[7:0]};
                        default: r_data = ram_rdata;
                    endcase
                end
                // high RAM bytes fill the bottom of rt
                LS_LWR: begin
                    case (off)
                        2'd0:    r_data = ram_rdata;
                        2'd1:    r_data = {rt[31:24], ram_rdata[31:8]};
                        2'd2:    r_data = {rt[31:16], ram_rdata[31:16]};
                        default: r_data = {rt[31:8], ram_rdata[31:24]};
                    endcase
                end
                default: r_data = 32'h0;
            endcase
        end
    end

    // a halfword load reaching here must have been trapped if odd
    always_comb begin
        if (req.ex.ls_ena && (req.ex.ls_sel inside {LS_LH, LS_LHU}) && !req.data_adel) begin
            assert (off[0] == 1'b0)
                else $error("odd halfword load passed without data_adel");
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data RAM depth in 32-bit words
`define LSU_RAM_WORDS 256

// word address width, taken from ls_addr[9:2]
`define LSU_RAM_AW 8

`endif

// ==== logic/lsu_op_pkg.sv ====
`default_nettype none

package lsu_op_pkg;

    // load/store access select, as decoded in the execute stage
    typedef enum logic [3:0] {
        LS_LB  = 4'd0,
        LS_LBU = 4'd1,
        LS_LH  = 4'd2,
        LS_LHU = 4'd3,
        LS_LW  = 4'd4,
        LS_LWL = 4'd5,
        LS_LWR = 4'd6,
        LS_SB  = 4'd7,
        LS_SH  = 4'd8,
        LS_SW  = 4'd9,
        LS_SWL = 4'd10,
        LS_SWR = 4'd11
    } ls_sel_e;

    typedef enum logic [1:0] {
        AL_NONE = 2'd0,
        AL_BYTE = 2'd1,
        AL_HALF = 2'd2,
        AL_WORD = 2'd3
    } align_e;

    function automatic logic is_store(ls_sel_e sel);
        return sel inside {LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR};
    endfunction

    // unaligned LWL/LWR/SWL/SWR never trap
    function automatic align_e needs_align(ls_sel_e sel);
        case (sel)
            LS_LB, LS_LBU, LS_SB: return AL_BYTE;
            LS_LH, LS_LHU, LS_SH: return AL_HALF;
            LS_LW, LS_SW:         return AL_WORD;
            default:              return AL_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/lsu_stage_pkg.sv ====
`default_nettype none

package lsu_stage_pkg;

    import lsu_op_pkg::*;

    // execute to memory stage payload
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_res;
        logic [31:0] ls_addr;
        logic [31:0] rt_data;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        ls_ena;
        ls_sel_e     ls_sel;
        logic        wb_reg_sel;
        logic        has_exception;
    } ex_mem_t;

    // request held between RAM access and load alignment
    typedef struct packed {
        ex_mem_t ex;
        logic    data_adel;
        logic    data_ades;
    } mem_req_t;

    // memory to writeback payload
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_res;
        logic [31:0] r_data;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        wb_reg_sel;
        logic        has_exception;
        logic        data_adel;
        logic        data_ades;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== logic/mem_access_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_align
    import lsu_op_pkg::*, lsu_stage_pkg::*;
(
    input  ex_mem_t     ex_req,
    output logic        data_adel,
    output logic        data_ades,
    output logic [3:0]  wr_strb,
    output logic [31:0] wr_data
);

    logic [1:0]  off;
    logic        misaligned;
    logic        store;
    logic [31:0] rt;

    assign off   = ex_req.ls_addr[1:0];
    assign store = is_store(ex_req.ls_sel);
    assign rt    = ex_req.rt_data;

    always_comb begin
        case (needs_align(ex_req.ls_sel))
            AL_HALF: misaligned = off[0];
            AL_WORD: misaligned = (off != 2'b00);
            default: misaligned = 1'b0;
        endcase
    end

    assign data_adel = ex_req.ls_ena & misaligned & ~store;
    assign data_ades = ex_req.ls_ena & misaligned & store;

    // lane steering, little-endian
    always_comb begin
        wr_strb = 4'b0000;
        wr_data = rt;
        if (ex_req.ls_ena) begin
            case (ex_req.ls_sel)
                LS_SB: begin
                    wr_strb = 4'b0001 << off;
                    wr_data = {4{rt[7:0]}};
                end
                LS_SH: begin
                    wr_strb = off[1] ? 4'b1100 : 4'b0011;
                    wr_data = {2{rt[15:0]}};
                end
                LS_SW: begin
                    wr_strb = 4'b1111;
                end
                // upper bytes of rt land in the low lanes
                LS_SWL: begin
                    wr_strb = 4'b1111 >> (2'd3 - off);
                    wr_data = rt >> (8 * (2'd3 - off));
                end
                LS_SWR: begin
                    wr_strb = 4'b1111 << off;
                    wr_data = rt << (8 * off);
                end
                default: begin
                    wr_strb = 4'b0000;
                end
            endcase
        end
    end

    // lane decode must agree with the store decode
    always_comb begin
        if (!store) begin
            assert (wr_strb == 4'b0000)
                else $error("byte strobe raised for a load");
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module mem_stage
    import lsu_op_pkg::*, lsu_stage_pkg::*;
(
    input  wire     clk,
    input  wire     arst_n,
    input  logic    ex_valid,
    input  ex_mem_t ex_req,
    output logic    wb_valid,
    output mem_wb_t wb_out
);

    logic                   data_adel;
    logic                   data_ades;
    logic [3:0]             wr_strb;
    logic [31:0]            wr_data;
    logic                   ram_wr_en;
    logic [`LSU_RAM_AW-1:0] ram_addr;
    logic [31:0]            ram_rdata;
    mem_req_t               req_d;
    mem_req_t               req_q;
    logic                   req_valid;
    logic [31:0]            load_data;
    logic                   exc;
    mem_wb_t                wb_d;

    mem_access_align u_align (
        .ex_req    (ex_req),
        .data_adel (data_adel),
        .data_ades (data_ades),
        .wr_strb   (wr_strb),
        .wr_data   (wr_data)
    );

    // faulting or already excepted stores must not touch memory
    assign ram_wr_en = ex_valid & ex_req.ls_ena & is_store(ex_req.ls_sel)
                     & ~data_ades & ~ex_req.has_exception;
    assign ram_addr  = ex_req.ls_addr[`LSU_RAM_AW+1:2];

    data_ram u_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_strb (wr_strb),
        .addr    (ram_addr),
        .wr_data (wr_data),
        .rd_data (ram_rdata)
    );

    assign req_d = '{ex: ex_req, data_adel: data_adel, data_ades: data_ades};

    stage_reg #(.payload_t(mem_req_t)) u_ex_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (ex_valid),
        .in_data   (req_d),
        .out_valid (req_valid),
        .out_data  (req_q)
    );

    load_align u_load (
        .req       (req_q),
        .ram_rdata (ram_rdata),
        .r_data    (load_data)
    );

    assign exc = req_q.ex.has_exception | req_q.data_adel | req_q.data_ades;

    always_comb begin
        wb_d.pc            = req_q.ex.pc;
        wb_d.alu_res       = req_q.ex.alu_res;
        wb_d.r_data        = load_data;
        wb_d.w_reg_ena     = req_q.ex.w_reg_ena & ~exc;
        wb_d.w_reg_dst     = req_q.ex.w_reg_dst;
        wb_d.wb_reg_sel    = req_q.ex.wb_reg_sel;
        wb_d.has_exception = exc;
        wb_d.data_adel     = req_q.data_adel;
        wb_d.data_ades     = req_q.data_ades;
    end

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (req_valid),
        .in_data   (wb_d),
        .out_valid (wb_valid),
        .out_data  (wb_out)
    );

    a_exc_blocks_wb: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb_valid && wb_out.has_exception) |-> !wb_out.w_reg_ena
    ) else $error("register write enabled on an excepting instruction");

endmodule

`default_nettype wire

// ==== logic/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload follows every cycle, qualified by out_valid
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

`default_nettype wire

// ==== verification/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import lsu_op_pkg::*, lsu_stage_pkg::*;
();

    // about 300 cycles of tests, with margin
    localparam int MAX_CYCLES = 1000;

    typedef struct packed {
        mem_wb_t wb;
        int      due;
    } exp_t;

    logic       clk;
    logic       arst_n;
    logic       ex_valid;
    ex_mem_t    ex_req;
    logic       wb_valid;
    mem_wb_t    wb_out;
    logic [7:0] shadow [1024];
    exp_t       exp_q [$];
    int         cycle = 0;
    int         err_cnt = 0;
    int         err_mark = 0;
    int         n_pass = 0;
    int         n_fail = 0;
    int         n_issued = 0;
    int         seed = 24162;

    mem_stage dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .ex_valid (ex_valid),
        .ex_req   (ex_req),
        .wb_valid (wb_valid),
        .wb_out   (wb_out)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic writes_mem(input ls_sel_e sel);
        return sel inside {LS_SB, LS_SH, LS_SW, LS_SWL, LS_SWR};
    endfunction

    // little-endian byte model of one access; updates the shadow memory for stores
    task automatic model_access(input ex_mem_t r, output mem_wb_t w);
        logic [7:0]  wa;
        logic [7:0]  b [4];
        logic [31:0] rd;
        logic        st;
        logic        mis;
        int          k;
        wa = r.ls_addr[9:2];
        k  = int'(r.ls_addr[1:0]);
        st = writes_mem(r.ls_sel);
        rd = 32'h0;
        for (int i = 0; i < 4; i++) begin
            b[i] = shadow[{wa, 2'(i)}];
        end
        case (r.ls_sel)
            LS_LH, LS_LHU, LS_SH: mis = (k % 2) != 0;
            LS_LW, LS_SW:         mis = k != 0;
            default:              mis = 1'b0;
        endcase
        if (!mis) begin
            case (r.ls_sel)
                LS_LB:  rd = {{24{b[k][7]}}, b[k]};
                LS_LBU: rd = {24'h0, b[k]};
                LS_LH:  rd = {{16{b[k+1][7]}}, b[k+1], b[k]};
                LS_LHU: rd = {16'h0, b[k+1], b[k]};
                LS_LW:  rd = {b[3], b[2], b[1], b[0]};
                LS_LWL: begin
                    rd = r.rt_data;
                    for (int i = 0; i <= k; i++) rd[8*(3-k+i) +: 8] = b[i];
                end
                LS_LWR: begin
                    rd = r.rt_data;
                    for (int i = k; i < 4; i++) rd[8*(i-k) +: 8] = b[i];
                end
                default: rd = 32'h0;
            endcase
        end
        if (!mis && !r.has_exception) begin
            case (r.ls_sel)
                LS_SB: shadow[{wa, 2'(k)}] = r.rt_data[7:0];
                LS_SH: begin
                    shadow[{wa, 2'(k)}]     = r.rt_data[7:0];
                    shadow[{wa, 2'(k + 1)}] = r.rt_data[15:8];
                end
                LS_SW: for (int i = 0; i < 4; i++) shadow[{wa, 2'(i)}] = r.rt_data[8*i +: 8];
                LS_SWL: for (int i = 0; i <= k; i++) begin
                    shadow[{wa, 2'(i)}] = r.rt_data[8*(3-k+i) +: 8];
                end
                LS_SWR: for (int i = k; i < 4; i++) begin
                    shadow[{wa, 2'(i)}] = r.rt_data[8*(i-k) +: 8];
                end
                default: ;
            endcase
        end
        w.pc            = r.pc;
        w.alu_res       = r.alu_res;
        w.r_data        = rd;
        w.has_exception = r.has_exception | mis;
        w.w_reg_ena     = r.w_reg_ena & ~(r.has_exception | mis);
        w.w_reg_dst     = r.w_reg_dst;
        w.wb_reg_sel    = r.wb_reg_sel;
        w.data_adel     = mis & ~st;
        w.data_ades     = mis & st;
    endtask

    task automatic issue(input ls_sel_e sel, input logic [31:0] addr, input logic [31:0] rt,
                         input logic exc);
        ex_mem_t r;
        exp_t    e;
        @(negedge clk);
        r.pc            = 32'h0040_0000 + 32'(4 * n_issued);
        r.alu_res       = $random(seed);
        r.ls_addr       = addr;
        r.rt_data       = rt;
        r.w_reg_ena     = ~writes_mem(sel);
        r.w_reg_dst     = 5'($random(seed));
        r.ls_ena        = 1'b1;
        r.ls_sel        = sel;
        r.wb_reg_sel    = ~writes_mem(sel);
        r.has_exception = exc;
        ex_req   = r;
        ex_valid = 1'b1;
        model_access(r, e.wb);
        // sampled at the next edge, result registered one edge later
        e.due = cycle + 2;
        exp_q.push_back(e);
        n_issued++;
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        ex_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        if (err_cnt == err_mark) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s failed with %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (actv === expv) else begin
            $display("MISMATCH %s expected %h actual %h", name, expv, actv);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!arst_n) begin
            assert (!wb_valid) else begin
                $display("wb_valid went high during reset");
                err_cnt++;
            end
        end else if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            assert (wb_valid) else begin
                $display("result missing two cycles after its request");
                err_cnt++;
            end
            check_field("pc", exp_q[0].wb.pc, wb_out.pc);
            check_field("alu_res", exp_q[0].wb.alu_res, wb_out.alu_res);
            check_field("r_data", exp_q[0].wb.r_data, wb_out.r_data);
            check_field("w_reg_ena", 32'(exp_q[0].wb.w_reg_ena), 32'(wb_out.w_reg_ena));
            check_field("w_reg_dst", 32'(exp_q[0].wb.w_reg_dst), 32'(wb_out.w_reg_dst));
            check_field("wb_reg_sel", 32'(exp_q[0].wb.wb_reg_sel), 32'(wb_out.wb_reg_sel));
            check_field("has_exception", 32'(exp_q[0].wb.has_exception),
                        32'(wb_out.has_exception));
            check_field("data_adel", 32'(exp_q[0].wb.data_adel), 32'(wb_out.data_adel));
            check_field("data_ades", 32'(exp_q[0].wb.data_ades), 32'(wb_out.data_ades));
            void'(exp_q.pop_front());
        end else begin
            assert (!wb_valid) else begin
                $display("wb_valid high with no result due");
                err_cnt++;
            end
        end
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("run stopped after %0d cycles without finishing", cycle);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        arst_n   = 1'b0;
        ex_valid = 1'b0;
        ex_req   = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // fill words 0..15 so every load reads known data
        for (int a = 0; a < 16; a++) begin
            issue(LS_SW, 32'(4 * a), (32'(a) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3, 1'b0);
        end
        issue(LS_LW, 32'h0000_0008, 32'h0, 1'b0);
        finish_test("reset_latency");

        for (int i = 0; i < 4; i++) begin
            issue(LS_SW, 32'(4 * i), $random(seed), 1'b0);
            issue(LS_LW, 32'(4 * i), 32'h0, 1'b0);
        end
        finish_test("sw_lw_back_to_back");

        for (int k = 0; k < 4; k++) begin
            issue(LS_SB, 32'(16 + k), $random(seed), 1'b0);
            issue(LS_LB, 32'(16 + k), 32'h0, 1'b0);
            issue(LS_LBU, 32'(16 + k), 32'h0, 1'b0);
            issue(LS_LW, 32'h10, 32'h0, 1'b0);
            if (k % 2 == 0) begin
                issue(LS_SH, 32'(20 + k), $random(seed), 1'b0);
                issue(LS_LH, 32'(20 + k), 32'h0, 1'b0);
                issue(LS_LHU, 32'(20 + k), 32'h0, 1'b0);
                issue(LS_LW, 32'h14, 32'h0, 1'b0);
            end
        end
        finish_test("byte_half");

        for (int k = 0; k < 4; k++) begin
            issue(LS_SWL, 32'(32 + k), $random(seed), 1'b0);
            issue(LS_LW, 32'h20, 32'h0, 1'b0);
            issue(LS_LWL, 32'(32 + k), $random(seed), 1'b0);
            issue(LS_SWR, 32'(36 + k), $random(seed), 1'b0);
            issue(LS_LW, 32'h24, 32'h0, 1'b0);
            issue(LS_LWR, 32'(36 + k), $random(seed), 1'b0);
        end
        finish_test("unaligned_merge");

        issue(LS_LH, 32'h31, 32'h0, 1'b0);
        issue(LS_LHU, 32'h33, 32'h0, 1'b0);
        issue(LS_LW, 32'h32, 32'h0, 1'b0);
        issue(LS_SH, 32'h31, $random(seed), 1'b0);
        issue(LS_SW, 32'h33, $random(seed), 1'b0);
        issue(LS_LW, 32'h30, 32'h0, 1'b0);
        issue(LS_SW, 32'h34, $random(seed), 1'b1);
        issue(LS_LW, 32'h34, 32'h0, 1'b0);
        finish_test("address_errors");

        // upper address bits are random and must be ignored
        for (int i = 0; i < 200; i++) begin
            issue(ls_sel_e'(4'($unsigned($random(seed)) % 12)),
                  $random(seed) & 32'hFFFF_FC3F, $random(seed), 1'b0);
        end
        finish_test("random_mix");

        $display("tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, err_cnt);
        if (n_fail == 0 && err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
